//--- all.f
common/pet_bus_pkg.sv
hw/addr_decode.sv
hw/sram_bank.sv
hw/io_regs.sv
hw/bus_resolver/bus_resolver.sv
hw/bus_sequencer/bus_sequencer.sv
hw/pet_bus_top.sv
tests/bus_resolver_chk.sv
tests/pet_bus_tb.sv

//--- tests/pet_bus_tb.sv
// PET bus testbench.
// Applies a table of host and CPU accesses to the bus top level and checks
// read data, the host handshake, back-pressure and contention.

`timescale 1ns/1ps

module pet_bus_tb;

    localparam int   NUM_ENTRIES = 14;
    localparam int   CYCLE_LIMIT = 40 * NUM_ENTRIES + 200;
    localparam logic SRC_HOST    = 1'b0;
    localparam logic SRC_CPU     = 1'b1;

    // One table row. Hold is the number of cycles the CPU keeps the bus.
    typedef struct packed {
        logic        src;
        logic        we_n;
        logic [15:0] addr;
        logic [7:0]  wdata;
        logic [3:0]  hold;
        logic [7:0]  exp_rdata;
    } entry_t;

    logic                   clock_i;
    logic                   rst_n_i;
    logic                   host_req_valid_i;
    pet_bus_pkg::bus_req_t  host_req_i;
    logic                   host_ack_o;
    pet_bus_pkg::bus_rsp_t  host_rsp_o;
    logic                   cpu_be_i;
    pet_bus_pkg::bus_req_t  cpu_req_i;
    logic                   host_busy_o;
    logic [7:0]             bus_data_o;
    logic                   contention_o;

    entry_t     stim_table [NUM_ENTRIES];
    int         n_entries;
    int         cycles;
    logic       ack_prev;
    logic [7:0] ref_ram [1024];   // Reference image of the 1 KB bank.
    logic [7:0] ref_io  [16];

    pet_bus_top dut (
        .clock_i, .rst_n_i,
        .host_req_valid_i, .host_req_i, .host_ack_o, .host_rsp_o,
        .cpu_be_i, .cpu_req_i, .host_busy_o,
        .bus_data_o, .contention_o
    );

    initial clock_i = 1'b0;
    always #5 clock_i = ~clock_i;

    task automatic fail_run();
        $display("tests failed");
        $fatal(1, "Stopped at the first error.");
    endtask

    task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
        assert (got === exp) else begin
            $display("Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            fail_run();
        end
    endtask

    // Run limit.
    always @(posedge clock_i) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the run went past %0d cycles.", CYCLE_LIMIT);
            fail_run();
        end
    end

    // Four-phase order. Inputs change by NBA, so these are the held values.
    always @(negedge clock_i) begin
        if (rst_n_i) begin
            if (host_ack_o && !ack_prev) begin
                assert (host_req_valid_i) else begin
                    $display("Error at %0t ns: host_ack_o rose without a request.", $time);
                    fail_run();
                end
            end
            if (!host_ack_o && ack_prev) begin
                assert (!host_req_valid_i) else begin
                    $display("Error at %0t ns: host_ack_o fell while the request was high.",
                             $time);
                    fail_run();
                end
            end
        end
        ack_prev = host_ack_o;
    end

    // Expected read data from the PET memory map.
    function automatic logic [7:0] model_read(input logic [15:0] addr);
        if (addr < 16'h8000) return ref_ram[addr[9:0]];            // 1 KB aliasing.
        if (addr >= 16'hE800 && addr < 16'hE810) return ref_io[addr[3:0]];
        return 8'hFF;                                              // Pulled-up bus.
    endfunction

    task automatic add_entry(input logic src, input logic we_n, input logic [15:0] addr,
                             input logic [7:0] wdata, input logic [3:0] hold);
        entry_t e;
        e.src   = src;
        e.we_n  = we_n;
        e.addr  = addr;
        e.wdata = wdata;
        e.hold  = hold;
        if (!we_n) begin
            if (addr < 16'h8000) ref_ram[addr[9:0]] = wdata;
            else if (addr >= 16'hE800 && addr < 16'hE810) ref_io[addr[3:0]] = wdata;
            e.exp_rdata = wdata;                                   // Data seen on the bus.
        end else begin
            e.exp_rdata = model_read(addr);
        end
        stim_table[n_entries] = e;
        n_entries++;
    endtask

    task automatic build_table();
        for (int i = 0; i < 1024; i++) ref_ram[i] = 8'h00;        // Memories clear on reset.
        for (int i = 0; i < 16; i++) ref_io[i] = 8'h00;
        n_entries = 0;
        add_entry(SRC_HOST, 1'b0, 16'h0123, 8'hA5, 4'd0);
        add_entry(SRC_HOST, 1'b1, 16'h0123, 8'h00, 4'd0);
        add_entry(SRC_HOST, 1'b1, 16'h0523, 8'h00, 4'd0);          // Alias of 0123.
        add_entry(SRC_HOST, 1'b0, 16'hE805, 8'h3C, 4'd0);
        add_entry(SRC_HOST, 1'b1, 16'hE805, 8'h00, 4'd0);
        add_entry(SRC_HOST, 1'b1, 16'hF000, 8'h00, 4'd0);          // Unmapped.
        add_entry(SRC_CPU,  1'b0, 16'h2040, 8'h5A, 4'd0);
        add_entry(SRC_HOST, 1'b1, 16'h2040, 8'h00, 4'd0);
        add_entry(SRC_HOST, 1'b0, 16'h0300, 8'hC3, 4'd0);
        add_entry(SRC_CPU,  1'b1, 16'h0700, 8'h00, 4'd0);          // CPU reads the alias.
        add_entry(SRC_HOST, 1'b0, 16'h0011, 8'h77, 4'd5);          // Back-pressure.
        add_entry(SRC_HOST, 1'b1, 16'h0011, 8'h00, 4'd3);
        add_entry(SRC_CPU,  1'b1, 16'hE805, 8'h00, 4'd0);
        add_entry(SRC_CPU,  1'b1, 16'h9000, 8'h00, 4'd0);
    endtask

    // Host transfer through the four-phase handshake.
    task automatic apply_host(input entry_t e);
        pet_bus_pkg::bus_req_t req;
        pet_bus_pkg::bus_req_t cpu_rd;
        int                    waited;
        req.addr     = e.addr;
        req.wdata    = e.wdata;
        req.we_n     = e.we_n;
        cpu_rd.addr  = e.addr;
        cpu_rd.wdata = 8'h00;
        cpu_rd.we_n  = 1'b1;
        host_req_i       <= req;
        host_req_valid_i <= 1'b1;
        if (e.hold != 0) begin
            cpu_req_i <= cpu_rd;                                   // CPU still reading.
            cpu_be_i  <= 1'b1;
        end
        for (int i = 0; i < e.hold; i++) begin
            @(negedge clock_i);
            check_value("host_ack_o", host_ack_o, 1'b0);
            check_value("host_busy_o", host_busy_o, 1'b1);
            check_value("contention_o", contention_o, 1'b0);
        end
        if (e.hold != 0) cpu_be_i <= 1'b0;
        waited = 0;
        do begin
            @(negedge clock_i);
            waited++;
        end while (!host_ack_o);
        // Sampled half a cycle after the drive, ack 3 cycles later.
        if (e.hold == 0) check_value("ack latency (falling edges)", waited, 4);
        if (e.we_n) check_value("host_rsp_o", host_rsp_o.rdata, e.exp_rdata);
        host_req_valid_i <= 1'b0;
        do @(negedge clock_i); while (host_ack_o);
        check_value("host_busy_o", host_busy_o, 1'b0);
        @(negedge clock_i);                                        // RELEASE back to IDLE.
    endtask

    // One CPU bus cycle on the pins.
    task automatic apply_cpu(input entry_t e);
        pet_bus_pkg::bus_req_t req;
        req.addr  = e.addr;
        req.wdata = e.wdata;
        req.we_n  = e.we_n;
        cpu_req_i <= req;
        cpu_be_i  <= 1'b1;
        @(negedge clock_i);
        check_value("bus_data_o", bus_data_o, e.exp_rdata);       // Same-cycle data.
        cpu_be_i  <= 1'b0;
    endtask

    initial begin
        rst_n_i          = 1'b0;
        host_req_valid_i = 1'b0;
        host_req_i       = '0;
        cpu_be_i         = 1'b0;
        cpu_req_i        = '0;
        cycles           = 0;
        ack_prev         = 1'b0;
        void'($urandom(54));
        build_table();
        repeat (5) @(negedge clock_i);
        rst_n_i <= 1'b1;
        @(negedge clock_i);
        check_value("host_ack_o", host_ack_o, 1'b0);
        check_value("host_busy_o", host_busy_o, 1'b0);
        check_value("contention_o", contention_o, 1'b0);
        for (int i = 0; i < n_entries; i++) begin
            repeat ($urandom_range(3)) @(negedge clock_i);         // Idle gap.
            if (stim_table[i].src == SRC_HOST) apply_host(stim_table[i]);
            else apply_cpu(stim_table[i]);
            check_value("contention_o", contention_o, 1'b0);
        end
        repeat (2) @(negedge clock_i);
        if (dut.u_resolver.u_chk.fail_count == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            $display("Bound resolver assertions failed %0d times.",
                     dut.u_resolver.u_chk.fail_count);
            fail_run();
        end
    end

endmodule

//--- tests/bus_resolver_chk.sv
// Resolver protocol checker.
// Bound into bus_resolver to watch the data driver set, the host output
// enables against CPU bus ownership, and the contention flag.

`timescale 1ns/1ps

module bus_resolver_chk (
    input  logic                       clock_i,
    input  logic                       rst_n_i,
    input  logic                       top_addr_oe_i,
    input  logic                       top_data_oe_i,
    input  logic                       top_we_oe_i,
    input  logic                       cpu_be_i,
    input  pet_bus_pkg::bus_drivers_t  drivers_i,
    input  logic                       contention_i
);

    int   fail_count = 0;   // Read by the testbench at the end of the run.
    logic host_oe;

    assign host_oe = top_addr_oe_i || top_data_oe_i || top_we_oe_i;  // Any host drive.

    // At most one party on the data lines.
    drivers_onehot: assert property (@(posedge clock_i) disable iff (!rst_n_i)
        $onehot0(drivers_i))
        else begin
            $error("More than one data driver on the bus.");
            fail_count++;
        end

    // Host stays off the bus while the CPU owns it.
    no_oe_under_be: assert property (@(posedge clock_i) disable iff (!rst_n_i)
        !(cpu_be_i && host_oe))
        else begin
            $error("Host output enable raised while cpu_be_i is high.");
            fail_count++;
        end

    no_contention: assert property (@(posedge clock_i) disable iff (!rst_n_i)
        !contention_i)
        else begin
            $error("Contention flag raised.");
            fail_count++;
        end

endmodule

bind bus_resolver bus_resolver_chk u_chk (
    .clock_i, .rst_n_i,
    .top_addr_oe_i, .top_data_oe_i, .top_we_oe_i,
    .cpu_be_i,
    .drivers_i    (drivers_o),
    .contention_i (contention_o)
);

//--- hw/pet_bus_top.sv
// PET bus top level.
// Wires the host sequencer, resolver, decoder and the two slaves together,
// with the 6502 bus pins brought out as ports.

`timescale 1ns/1ps

module pet_bus_top (
    input  logic                                clock_i,
    input  logic                                rst_n_i,

    // Host port.
    input  logic                                host_req_valid_i,
    input  pet_bus_pkg::bus_req_t               host_req_i,
    output logic                                host_ack_o,
    output pet_bus_pkg::bus_rsp_t               host_rsp_o,

    // CPU pins.
    input  logic                                cpu_be_i,
    input  pet_bus_pkg::bus_req_t               cpu_req_i,
    output logic                                host_busy_o,

    output logic [pet_bus_pkg::DATA_WIDTH-1:0]  bus_data_o,
    output logic                                contention_o
);

    pet_bus_pkg::bus_req_t              top_req;
    logic                               addr_oe;
    logic                               data_oe;
    logic                               we_oe;
    pet_bus_pkg::bus_req_t              bus_req;      // Resolved bus.
    pet_bus_pkg::chip_sel_t             sel;
    logic [pet_bus_pkg::DATA_WIDTH-1:0] ram_rdata;
    logic                               ram_oe_n;
    logic [pet_bus_pkg::DATA_WIDTH-1:0] io_rdata;
    logic                               io_oe_n;

    bus_sequencer u_seq (
        .clock_i, .rst_n_i,
        .host_req_valid_i, .host_req_i, .host_ack_o, .host_rsp_o,
        .cpu_be_i, .host_busy_o,
        .bus_data_i (bus_req.wdata),
        .top_req_o  (top_req),
        .addr_oe_o  (addr_oe),
        .data_oe_o  (data_oe),
        .we_oe_o    (we_oe)
    );

    bus_resolver u_resolver (
        .clock_i, .rst_n_i,
        .top_req_i     (top_req),
        .top_addr_oe_i (addr_oe),
        .top_data_oe_i (data_oe),
        .top_we_oe_i   (we_oe),
        .cpu_be_i, .cpu_req_i,
        .ram_rdata_i   (ram_rdata),
        .ram_oe_n_i    (ram_oe_n),
        .io_rdata_i    (io_rdata),
        .io_oe_n_i     (io_oe_n),
        .bus_o         (bus_req),
        .drivers_o     (),                             // Observed by the bound checker.
        .contention_o
    );

    addr_decode u_decode (.addr_i (bus_req.addr), .sel_o (sel));

    sram_bank u_sram (
        .clock_i, .rst_n_i,
        .cs_i (sel.ram_cs), .index_i (sel.index),
        .we_n_i (bus_req.we_n), .wdata_i (bus_req.wdata),
        .rdata_o (ram_rdata), .oe_n_o (ram_oe_n)
    );

    io_regs u_io (
        .clock_i, .rst_n_i,
        .cs_i (sel.io_cs), .index_i (sel.index[pet_bus_pkg::IO_INDEX_WIDTH-1:0]),
        .we_n_i (bus_req.we_n), .wdata_i (bus_req.wdata),
        .rdata_o (io_rdata), .oe_n_o (io_oe_n)
    );

    assign bus_data_o = bus_req.wdata;   // Resolved data lines.

endmodule

//--- hw/bus_sequencer/bus_sequencer.sv
// Host bus sequencer.
// Runs one host transfer per four-phase req/ack handshake, waits for the CPU
// to release the bus, drives the access and returns read data with the ack.

`timescale 1ns/1ps

module bus_sequencer (
    input  logic                                clock_i,
    input  logic                                rst_n_i,

    // Host port, four-phase handshake.
    input  logic                                host_req_valid_i,
    input  pet_bus_pkg::bus_req_t               host_req_i,
    output logic                                host_ack_o,
    output pet_bus_pkg::bus_rsp_t               host_rsp_o,

    // CPU side.
    input  logic                                cpu_be_i,
    output logic                                host_busy_o,

    // Resolved data lines, used for reads.
    input  logic [pet_bus_pkg::DATA_WIDTH-1:0]  bus_data_i,

    // Drive side towards the resolver.
    output pet_bus_pkg::bus_req_t               top_req_o,
    output logic                                addr_oe_o,
    output logic                                data_oe_o,
    output logic                                we_oe_o
);

    typedef enum logic [2:0] {
        IDLE,       // Waiting for a request.
        WAIT_BUS,   // Request taken, CPU still owns the bus.
        ADDR,       // Address, WE and write data on the bus.
        STROBE,     // Slave commits or answers.
        ACK,        // Ack high until the host drops its request.
        RELEASE     // Ack low again, back to idle.
    } seq_state_e;

    seq_state_e             state_q;
    seq_state_e             state_d;
    pet_bus_pkg::bus_req_t  req_q;       // Copy of the host request.
    pet_bus_pkg::bus_rsp_t  rsp_q;       // Result stage.
    logic                   on_bus;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:     if (host_req_valid_i) state_d = WAIT_BUS;
            WAIT_BUS: if (!cpu_be_i)        state_d = ADDR;   // Back-pressure from CPU.
            ADDR:                           state_d = STROBE;
            STROBE:                         state_d = ACK;
            ACK:      if (!host_req_valid_i) state_d = RELEASE;
            RELEASE:                        state_d = IDLE;
            default:                        state_d = IDLE;
        endcase
    end

    always_ff @(posedge clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Request is stable while valid, so one sample at the start is enough.
    always_ff @(posedge clock_i) begin
        if (state_q == IDLE && host_req_valid_i) begin
            req_q <= host_req_i;
        end
    end

    // Read data is latched at the end of the strobe cycle.
    always_ff @(posedge clock_i) begin
        if (state_q == STROBE && req_q.we_n) begin
            rsp_q.rdata <= bus_data_i;
        end
    end

    assign on_bus = (state_q == ADDR) || (state_q == STROBE);

    assign top_req_o = req_q;
    assign addr_oe_o = on_bus;
    assign we_oe_o   = on_bus;
    assign data_oe_o = on_bus && !req_q.we_n;           // Only drive data on writes.

    // CPU must keep BE low from the pending request until the ack.
    assign host_busy_o = (state_q == WAIT_BUS) || on_bus;

    assign host_ack_o = (state_q == ACK);
    assign host_rsp_o = rsp_q;                          // Held stable through ACK.

endmodule

//--- hw/bus_resolver/bus_resolver.sv
// Bus resolver for the shared PET bus.
// Merges FPGA, CPU, SRAM and I/O drivers onto one address, data and WE set,
// and keeps a sticky flag when two parties drive the same lines.

`timescale 1ns/1ps

module bus_resolver (
    input  logic                                clock_i,
    input  logic                                rst_n_i,

    // FPGA host side.
    input  pet_bus_pkg::bus_req_t               top_req_i,
    input  logic                                top_addr_oe_i,
    input  logic                                top_data_oe_i,
    input  logic                                top_we_oe_i,

    // CPU pins.
    input  logic                                cpu_be_i,
    input  pet_bus_pkg::bus_req_t               cpu_req_i,

    // Slaves.
    input  logic [pet_bus_pkg::DATA_WIDTH-1:0]  ram_rdata_i,
    input  logic                                ram_oe_n_i,
    input  logic [pet_bus_pkg::DATA_WIDTH-1:0]  io_rdata_i,
    input  logic                                io_oe_n_i,

    output pet_bus_pkg::bus_req_t               bus_o,
    output pet_bus_pkg::bus_drivers_t           drivers_o,
    output logic                                contention_o
);

    logic [1:0]                 addr_set;    // {cpu, host}.
    logic [1:0]                 we_set;      // {cpu, host}.
    pet_bus_pkg::bus_drivers_t  data_set;
    logic                       collide;
    logic                       contention_q;

    assign addr_set = {cpu_be_i, top_addr_oe_i};   // CPU owns address while BE is high.
    assign we_set   = {cpu_be_i, top_we_oe_i};

    // Data drivers follow the pin rules of each party.
    always_comb begin
        data_set.host = top_data_oe_i;
        data_set.cpu  = cpu_be_i && !cpu_req_i.we_n;     // CPU only drives data on writes.
        data_set.ram  = !ram_oe_n_i && bus_o.we_n;       // Slaves only answer reads.
        data_set.io   = !io_oe_n_i && bus_o.we_n;
    end

    // Host wins every tie, so a collision still leaves defined values.
    always_comb begin
        bus_o = '1;                                      // Floating lines read as ones.
        if (top_addr_oe_i) bus_o.addr = top_req_i.addr;
        else if (cpu_be_i) bus_o.addr = cpu_req_i.addr;

        if (top_we_oe_i)   bus_o.we_n = top_req_i.we_n;
        else if (cpu_be_i) bus_o.we_n = cpu_req_i.we_n;

        if (data_set.host)      bus_o.wdata = top_req_i.wdata;
        else if (data_set.cpu)  bus_o.wdata = cpu_req_i.wdata;
        else if (data_set.ram)  bus_o.wdata = ram_rdata_i;
        else if (data_set.io)   bus_o.wdata = io_rdata_i;
        else                    bus_o.wdata = pet_bus_pkg::BUS_IDLE_DATA;
    end

    assign drivers_o = data_set;

    // More than one bit set in any driver group.
    assign collide = (&addr_set) || (&we_set) ||
                     ((data_set & (data_set - 4'd1)) != 4'd0);

    // Sticky until reset so a single-cycle clash is not missed.
    always_ff @(posedge clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            contention_q <= 1'b0;
        end else if (collide) begin
            contention_q <= 1'b1;
        end
    end

    assign contention_o = contention_q;

endmodule

//--- hw/io_regs.sv
// I/O register file slave.
// Sixteen byte registers in the I/O window, written on the clock edge and
// read combinationally like the SRAM.

`timescale 1ns/1ps

module io_regs (
    input  logic                                     clock_i,
    input  logic                                     rst_n_i,
    input  logic                                     cs_i,
    input  logic [pet_bus_pkg::IO_INDEX_WIDTH-1:0]   index_i,
    input  logic                                     we_n_i,
    input  logic [pet_bus_pkg::DATA_WIDTH-1:0]       wdata_i,
    output logic [pet_bus_pkg::DATA_WIDTH-1:0]       rdata_o,
    output logic                                     oe_n_o
);

    logic [pet_bus_pkg::DATA_WIDTH-1:0] regs_q [pet_bus_pkg::IO_REGS];
    logic                               wr_en;

    assign wr_en = cs_i && !we_n_i;         // Bus write into the window.

    // Registers come up as zero.
    always_ff @(posedge clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < pet_bus_pkg::IO_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en) begin
            regs_q[index_i] <= wdata_i;
        end
    end

    // Read path.
    assign rdata_o = regs_q[index_i];
    assign oe_n_o  = !(cs_i && we_n_i);     // Drive data only when selected and reading.

endmodule

//--- hw/sram_bank.sv
// SRAM bank slave.
// 1 KB of byte-wide RAM with a clocked write and a combinational read.

`timescale 1ns/1ps

module sram_bank (
    input  logic                                     clock_i,
    input  logic                                     rst_n_i,
    input  logic                                     cs_i,
    input  logic [pet_bus_pkg::SRAM_ADDR_WIDTH-1:0]  index_i,
    input  logic                                     we_n_i,
    input  logic [pet_bus_pkg::DATA_WIDTH-1:0]       wdata_i,
    output logic [pet_bus_pkg::DATA_WIDTH-1:0]       rdata_o,
    output logic                                     oe_n_o
);

    localparam int DEPTH = 1 << pet_bus_pkg::SRAM_ADDR_WIDTH;

    logic [pet_bus_pkg::DATA_WIDTH-1:0] mem [DEPTH];

    // Cleared on reset so reads start from a known image.
    always_ff @(posedge clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (cs_i && !we_n_i) begin
            mem[index_i] <= wdata_i;   // Byte commits at the edge.
        end
    end

    assign rdata_o = mem[index_i];          // Asynchronous read.
    assign oe_n_o  = !(cs_i && we_n_i);     // Output enable only for reads.

endmodule

//--- hw/addr_decode.sv
// Address decoder for the PET bus.
// Turns a bus address into the RAM and I/O chip selects and a local word index.

`timescale 1ns/1ps

module addr_decode (
    input  logic [pet_bus_pkg::CPU_ADDR_WIDTH-1:0] addr_i,
    output pet_bus_pkg::chip_sel_t                 sel_o
);

    logic ram_hit;
    logic io_hit;

    // RAM sits at the bottom of the map.
    assign ram_hit = (addr_i < pet_bus_pkg::RAM_LIMIT);

    // I/O window is a small block starting at IO_BASE.
    assign io_hit = (addr_i >= pet_bus_pkg::IO_BASE) &&
                    (addr_i <  pet_bus_pkg::IO_BASE + pet_bus_pkg::IO_REGS);

    always_comb begin
        sel_o        = '0;                  // Unmapped addresses select nothing.
        sel_o.ram_cs = ram_hit;
        sel_o.io_cs  = io_hit;              // Window lies above the RAM region.
        if (ram_hit) begin
            // Low bits only, so the bank repeats across the RAM region.
            sel_o.index = addr_i[pet_bus_pkg::SRAM_ADDR_WIDTH-1:0];
        end else if (io_hit) begin
            sel_o.index = {{(pet_bus_pkg::SRAM_ADDR_WIDTH - pet_bus_pkg::IO_INDEX_WIDTH){1'b0}},
                           addr_i[pet_bus_pkg::IO_INDEX_WIDTH-1:0]};
        end
    end

endmodule

//--- common/pet_bus_pkg.sv
// PET system bus package.
// Widths, the memory map and the structs shared by the bus blocks.

package pet_bus_pkg;

    // Bus widths.
    localparam int CPU_ADDR_WIDTH  = 16;   // 6502 address bus.
    localparam int DATA_WIDTH      = 8;    // 6502 data bus.

    // Memory map.
    localparam logic [CPU_ADDR_WIDTH-1:0] RAM_LIMIT = 16'h8000;  // RAM is 0000..7FFF.
    localparam int SRAM_ADDR_WIDTH = 10;   // RAM aliases every 1 KB.
    localparam logic [CPU_ADDR_WIDTH-1:0] IO_BASE = 16'hE800;    // Start of I/O window.
    localparam int IO_REGS         = 16;   // E800..E80F.
    localparam int IO_INDEX_WIDTH  = $clog2(IO_REGS);

    // Pull-ups make an undriven data bus read as all ones.
    localparam logic [DATA_WIDTH-1:0] BUS_IDLE_DATA = 8'hFF;

    // One bus access as seen on the pins.
    typedef struct packed {
        logic [CPU_ADDR_WIDTH-1:0] addr;   // Address lines.
        logic [DATA_WIDTH-1:0]     wdata;  // Data driven when writing.
        logic                      we_n;   // Low for a write.
    } bus_req_t;

    // Read result returned to the host.
    typedef struct packed {
        logic [DATA_WIDTH-1:0] rdata;
    } bus_rsp_t;

    // Who drives the data lines this cycle.
    typedef struct packed {
        logic host;
        logic cpu;
        logic ram;
        logic io;
    } bus_drivers_t;

    // Chip selects from the address decoder.
    typedef struct packed {
        logic                       ram_cs;
        logic                       io_cs;
        logic [SRAM_ADDR_WIDTH-1:0] index;   // Word index inside the selected slave.
    } chip_sel_t;

endpackage
